// File: dv/pkt_mux_tb.sv
// Directed testbench for the four-channel packet stream multiplexer.
// Per-channel drivers send packets, a monitor checks framing and payload
// against one expected queue per channel, and each test task covers one
// arbitration or flow-control behavior.

`include "pkt_mux_defs.svh"

module pkt_mux_tb import pkt_stream_pkg::*, pkt_arb_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int acc_limit   = 500;  // cycles one beat may wait for o_rdy.
  localparam int drain_limit = 2000; // cycles for the output to run empty.

  // one beat as the output is expected to show it.
  typedef struct packed {
    logic sop;
    logic eop;
    logic err;
    dat_t dat;
    mod_t mod;
    ctl_u ctl;
  } beat_t;

  logic                   i_clk;
  logic                   i_rst;
  arb_mode_e              i_mode;
  req_t                   i_val, i_sop, i_eop, i_err;
  dat_t [`PKT_NUM_IN-1:0] i_dat;
  mod_t [`PKT_NUM_IN-1:0] i_mod;
  ctl_u [`PKT_NUM_IN-1:0] i_ctl;
  req_t                   o_rdy;
  logic                   o_val, o_sop, o_eop, o_err;
  dat_t                   o_dat;
  mod_t                   o_mod;
  ctl_u                   o_ctl;
  logic                   i_rdy;
  cnt_t [`PKT_NUM_IN-1:0] o_pkt_cnt;

  int    seed;                      // state of the shared $random stream.
  int    err_cnt;
  int    test_cnt;
  int    test_fail_cnt;
  logic  bp_en;                     // random back-pressure on i_rdy while set.
  int    sent_cnt [`PKT_NUM_IN];    // packets fully accepted per channel.
  beat_t exp_q [`PKT_NUM_IN][$];    // scoreboard, one queue per channel.
  int    out_pkt_q [$];             // channel of each delivered packet, in order.
  logic  out_open;                  // the output is inside a packet.
  int    out_chan;

  pkt_mux_top pkt_mux_top_inst (.*);

  always #20 i_clk = ~i_clk;

  // the sink's ready, changed a little after each rising edge.
  always @(posedge i_clk) begin : rdy_drive
    logic [31:0] r;
    #5;
    r     = $random(seed);
    i_rdy = bp_en ? r[0] : 1'b1;
  end

  // --------------------
  // reporting.
  // --------------------
  task automatic note_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic check_dat(input string name, input dat_t exp, input dat_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected 0x%h got 0x%h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_ctl(input string name, input ctl_u exp, input ctl_u act);
    if (act.raw !== exp.raw) begin // the whole word, as the sink sees it.
      $display("CHECK FAILED %s expected 0x%h got 0x%h", name, exp.raw, act.raw);
      err_cnt++;
    end
  endtask

  task automatic check_mod(input string name, input mod_t exp, input mod_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected 0x%h got 0x%h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected 0x%h got 0x%h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected 0x%h got 0x%h", name, exp, act);
      err_cnt++;
    end
  endtask

  // --------------------
  // output monitor.
  // --------------------
  // a beat shown with o_val and i_rdy at the falling edge transfers at the next rising one.
  always @(negedge i_clk) begin : monitor
    int    ch;
    beat_t b;
    if (!i_rst && o_val && i_rdy) begin
      ch = int'(o_ctl.raw[`PKT_CTL_BITS-1 -: `PKT_CHAN_BITS]); // channel id sits on top.
      if (o_sop) begin
        if (out_open) note_failure("a new packet started inside an open output packet.");
        out_open = 1'b1;
        out_chan = ch;
      end else if (!out_open) begin
        note_failure("an output beat arrived outside of any packet.");
      end else if (ch != out_chan) begin
        note_failure($sformatf("channel %0d beat interleaved into a channel %0d packet.",
                               ch, out_chan));
      end
      if (o_eop) begin
        out_open = 1'b0;
        out_pkt_q.push_back(ch);
      end
      if (exp_q[ch].size() == 0) begin
        note_failure($sformatf("unexpected output beat for channel %0d.", ch));
      end else begin
        b = exp_q[ch].pop_front(); // order within a channel must be kept.
        check_flag("o_sop", b.sop, o_sop);
        check_flag("o_eop", b.eop, o_eop);
        check_flag("o_err", b.err, o_err);
        check_dat("o_dat", b.dat, o_dat);
        check_mod("o_mod", b.mod, o_mod);
        check_ctl("o_ctl", b.ctl, o_ctl);
      end
    end
  end

  // --------------------
  // drivers.
  // --------------------
  task automatic next_cycle();
    @(posedge i_clk);
    #5;
  endtask

  function automatic logic all_delivered();
    all_delivered = 1'b1;
    for (int c = 0; c < `PKT_NUM_IN; c++) begin
      if (exp_q[c].size() != 0) all_delivered = 1'b0;
    end
  endfunction

  // waits until every expected beat has left and the output register is empty.
  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge i_clk);
    while (!(all_delivered() && !o_val) && n < drain_limit) begin
      @(negedge i_clk);
      n++;
    end
    if (!(all_delivered() && !o_val)) begin
      note_failure("the output did not deliver every expected beat in time.");
      for (int c = 0; c < `PKT_NUM_IN; c++) exp_q[c].delete();
    end
    next_cycle();
  endtask

  // drives one packet on channel ch and holds each beat until o_rdy takes it.
  task automatic send_pkt(input int ch, input int nbeats, input logic with_err);
    logic [31:0]              r;
    logic [`PKT_CTL_BITS-1:0] raw_ctl;
    ctl_u                     src_ctl;
    beat_t                    b;
    int                       n;
    for (int i = 0; i < nbeats; i++) begin
      r           = $random(seed);
      raw_ctl     = r[15:8];
      src_ctl.raw = raw_ctl;
      b.sop       = (i == 0);
      b.eop       = (i == nbeats - 1);
      b.err       = b.eop && with_err && r[3];
      b.mod       = b.eop ? mod_t'(r[2:0]) : '0;
      b.dat       = {$random(seed), $random(seed)};
      // the output must show the channel number in place of the top bits.
      b.ctl.raw   = {chan_t'(ch), raw_ctl[`PKT_CTL_BITS-`PKT_CHAN_BITS-1:0]};
      exp_q[ch].push_back(b);
      i_val[ch] = 1'b1;
      i_sop[ch] = b.sop;
      i_eop[ch] = b.eop;
      i_err[ch] = b.err;
      i_dat[ch] = b.dat;
      i_mod[ch] = b.mod;
      i_ctl[ch] = src_ctl;
      n = 0;
      @(negedge i_clk);
      while (!o_rdy[ch] && n < acc_limit) begin
        @(negedge i_clk);
        n++;
      end
      if (!o_rdy[ch]) begin
        note_failure($sformatf("channel %0d beat %0d was never accepted.", ch, i));
        i_val[ch] = 1'b0;
        return;
      end
      next_cycle(); // the beat transfers on this edge.
    end
    i_val[ch] = 1'b0;
    sent_cnt[ch]++;
  endtask

  task automatic send_burst(input int ch, input int npkt, input int len_min,
                            input int len_max, input int idle_max, input logic with_err);
    logic [31:0] r;
    int          len;
    for (int p = 0; p < npkt; p++) begin
      r   = $random(seed);
      len = len_min + int'(r[15:0] % (len_max - len_min + 1));
      send_pkt(ch, len, with_err);
      repeat (int'(r[31:16] % (idle_max + 1))) next_cycle(); // gap between packets.
    end
  endtask

  task automatic finish_test(input string name, input int start);
    test_cnt++;
    if (err_cnt == start) begin
      $display("test %s: ok", name);
    end else begin
      test_fail_cnt++;
      $display("test %s: FAILED with %0d errors", name, err_cnt - start);
    end
  endtask

  // --------------------
  // tests.
  // --------------------
  task automatic test_reset_state();
    int start;
    start = err_cnt;
    check_flag("o_val", 1'b0, o_val);
    for (int c = 0; c < `PKT_NUM_IN; c++) begin
      check_flag($sformatf("o_rdy[%0d]", c), 1'b1, o_rdy[c]); // all stages empty.
      check_cnt($sformatf("o_pkt_cnt[%0d]", c), '0, o_pkt_cnt[c]);
    end
    finish_test("reset state", start);
  endtask

  task automatic test_single();
    int start;
    start  = err_cnt;
    i_mode = ARB_ROUND_ROBIN;
    send_pkt(2, 3, 1'b1);
    wait_drain();
    finish_test("single channel pass-through", start);
  endtask

  task automatic test_no_interleave();
    int start;
    start = err_cnt;
    fork
      send_burst(0, 3, 1, 4, 0, 1'b1);
      send_burst(1, 3, 1, 4, 0, 1'b1);
      send_burst(2, 3, 1, 4, 0, 1'b1);
      send_burst(3, 3, 1, 4, 0, 1'b1);
    join
    wait_drain(); // framing and per-channel order are checked by the monitor.
    finish_test("no interleaving", start);
  endtask

  task automatic test_round_robin();
    int   start;
    req_t seen;
    start  = err_cnt;
    i_mode = ARB_ROUND_ROBIN;
    out_pkt_q.delete();
    fork
      send_burst(0, 4, 2, 2, 0, 1'b0);
      send_burst(1, 4, 2, 2, 0, 1'b0);
      send_burst(2, 4, 2, 2, 0, 1'b0);
      send_burst(3, 4, 2, 2, 0, 1'b0);
    join
    wait_drain();
    if (out_pkt_q.size() != 16) begin
      note_failure($sformatf("round robin delivered %0d packets, not 16.", out_pkt_q.size()));
    end
    for (int i = 1; i < out_pkt_q.size(); i++) begin
      if (out_pkt_q[i] == out_pkt_q[i-1]) note_failure("one channel won twice in a row.");
    end
    // any four packets in a row must hold every channel once.
    for (int i = 0; i + `PKT_NUM_IN <= out_pkt_q.size(); i++) begin
      seen = '0;
      for (int j = 0; j < `PKT_NUM_IN; j++) seen[out_pkt_q[i+j]] = 1'b1;
      if (seen != '1) note_failure($sformatf("packets %0d to %0d skip a channel.", i, i + 3));
    end
    finish_test("round-robin fairness", start);
  endtask

  task automatic test_high_first();
    int start;
    int last3;
    start  = err_cnt;
    i_mode = ARB_HIGH_FIRST;
    out_pkt_q.delete();
    fork
      send_burst(3, 3, 2, 3, 0, 1'b0);
      begin
        repeat (2) next_cycle(); // channel 3 is pending before channel 0 starts.
        send_burst(0, 3, 2, 3, 0, 1'b0);
      end
    join
    wait_drain();
    last3 = -1;
    for (int i = 0; i < out_pkt_q.size(); i++) begin
      if (out_pkt_q[i] == 3) last3 = i;
    end
    if (out_pkt_q.size() != 6) note_failure("high-first mode lost or added packets.");
    for (int i = 0; i < last3; i++) begin
      if (out_pkt_q[i] == 0) note_failure("a channel 0 packet overtook channel 3.");
    end
    finish_test("high-first mode", start);
  endtask

  task automatic test_back_pressure();
    int start;
    start  = err_cnt;
    i_mode = ARB_ROUND_ROBIN;
    bp_en  = 1'b1;
    fork
      send_burst(0, 3, 1, 5, 2, 1'b1);
      send_burst(1, 3, 1, 5, 2, 1'b1);
      send_burst(2, 3, 1, 5, 2, 1'b1);
      send_burst(3, 3, 1, 5, 2, 1'b1);
    join
    bp_en = 1'b0;
    wait_drain();
    finish_test("back-pressure", start);
  endtask

  task automatic test_counters();
    int start;
    start = err_cnt;
    for (int c = 0; c < `PKT_NUM_IN; c++) begin
      check_cnt($sformatf("o_pkt_cnt[%0d]", c), cnt_t'(sent_cnt[c]), o_pkt_cnt[c]);
    end
    finish_test("delivered-packet counters", start);
  endtask

  // --------------------
  // main sequence.
  // --------------------
  initial begin
    seed          = 52;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    bp_en         = 1'b0;
    out_open      = 1'b0;
    out_chan      = 0;
    i_clk         = 1'b0;
    i_rst         = 1'b1;
    i_mode        = ARB_ROUND_ROBIN;
    i_val         = '0;
    i_sop         = '0;
    i_eop         = '0;
    i_err         = '0;
    i_dat         = '0;
    i_mod         = '0;
    i_ctl         = '0;
    i_rdy         = 1'b1;
    for (int c = 0; c < `PKT_NUM_IN; c++) sent_cnt[c] = 0;
    repeat (10) @(posedge i_clk);
    #5;
    i_rst = 1'b0;
    test_reset_state();
    test_single();
    test_no_interleave();
    test_round_robin();
    test_high_first();
    test_back_pressure();
    test_counters();
    $display("%0d tests run, %0d failed, %0d errors", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: hdl/pkt_arb.sv
// Packet-locked arbiter across the input channels.
// Routes one channel's beat to the output and stays on that channel
// until its end-of-packet beat transfers, so packets never interleave.
// The search order is round robin or highest channel first, set by i_mode.

`include "pkt_mux_defs.svh"

module pkt_arb import pkt_stream_pkg::*, pkt_arb_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  arb_mode_e             i_mode,
  // per-channel beats from the input stages.
  input  req_t                  i_val,
  input  req_t                  i_sop,
  input  req_t                  i_eop,
  input  req_t                  i_err,
  input  dat_t [`PKT_NUM_IN-1:0] i_dat,
  input  mod_t [`PKT_NUM_IN-1:0] i_mod,
  input  ctl_u [`PKT_NUM_IN-1:0] i_ctl,
  output req_t                  o_rdy,
  // selected beat towards the output stage.
  output logic                  o_val,
  output logic                  o_sop,
  output logic                  o_eop,
  output logic                  o_err,
  output dat_t                  o_dat,
  output mod_t                  o_mod,
  output ctl_u                  o_ctl,
  input  logic                  i_rdy
);

  chan_t ptr;      // channel currently routed to the output.
  logic  locked;   // set while a packet from ptr is in flight.
  chan_t nxt;      // next requesting channel in the current mode.
  logic  eop_xfer; // last beat of the routed packet transfers now.

  // Finds the next channel with a pending beat. Returns cur if none is pending.
  function automatic chan_t get_next(input arb_mode_e mode, input chan_t cur,
                                     input req_t req);
    chan_t cand;
    logic  found;
    get_next = cur;
    found    = 1'b0;
    for (int i = 0; i < `PKT_NUM_IN; i++) begin
      if (mode == ARB_ROUND_ROBIN) begin
        cand = chan_t'((int'(cur) + 1 + i) % `PKT_NUM_IN); // cur itself comes last.
      end else begin
        cand = chan_t'(`PKT_NUM_IN - 1 - i);
      end
      if (!found && req[cand]) begin
        get_next = cand;
        found    = 1'b1;
      end
    end
  endfunction

  // --------------------
  // beat routing.
  // --------------------
  always_comb begin
    o_rdy      = '0;
    o_rdy[ptr] = i_rdy; // only the routed channel sees downstream ready.
    o_val      = i_val[ptr];
    o_sop      = i_sop[ptr];
    o_eop      = i_eop[ptr];
    o_err      = i_err[ptr];
    o_dat      = i_dat[ptr];
    o_mod      = i_mod[ptr];
    o_ctl      = i_ctl[ptr];
  end

  assign nxt      = get_next(i_mode, ptr, i_val);
  assign eop_xfer = o_val && o_eop && i_rdy;

  // --------------------
  // pointer and lock.
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ptr    <= '0;
      locked <= 1'b0;
    end else if (locked) begin
      if (eop_xfer) begin
        locked <= 1'b0; // packet done, free to look elsewhere.
        ptr    <= nxt;
      end
    end else if (i_val[ptr] && !eop_xfer) begin
      // the routed channel has started a packet or is stalled mid-beat.
      locked <= 1'b1;
    end else begin
      ptr <= nxt; // idle channel or a single-beat packet just left.
    end
  end

  // never more than one channel may be granted.
  a_one_grant : assert property (@(posedge i_clk) disable iff (i_rst)
    $onehot0(o_rdy))
    else $error("arbiter granted more than one channel.");

  // a beat that leaves without closing its packet keeps the arbiter locked on that channel.
  a_lock_hold : assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && i_rdy && !o_eop |=> locked && $stable(ptr))
    else $error("arbiter left a channel in the middle of a packet.");

endmodule

// File: hdl/pkt_arb_pkg.sv
// Arbitration types for the packet multiplexer.
// Channel index, per-channel request vector and the run-time mode.

`include "pkt_mux_defs.svh"

package pkt_arb_pkg;

  // index of one input channel.
  typedef logic [`PKT_CHAN_BITS-1:0] chan_t;

  // one bit per channel, used for valid, ready and the markers.
  typedef logic [`PKT_NUM_IN-1:0] req_t;

  // --------------------
  // arbitration modes.
  // --------------------
  // round robin starts its search one past the current channel.
  // high first always starts at the highest channel number.
  typedef enum logic {
    ARB_ROUND_ROBIN = 1'b0,
    ARB_HIGH_FIRST  = 1'b1
  } arb_mode_e;

endpackage

// File: hdl/pkt_in_stage.sv
// Input register slice for one channel of the packet multiplexer.
// Holds one beat, takes a new one when empty or draining, and writes
// the channel id into the top bits of the control word.

module pkt_in_stage import pkt_stream_pkg::*, pkt_arb_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  chan_t i_chan,   // fixed id of this channel.
  // upstream side.
  input  logic  i_val,
  input  logic  i_sop,
  input  logic  i_eop,
  input  logic  i_err,
  input  dat_t  i_dat,
  input  mod_t  i_mod,
  input  ctl_u  i_ctl,
  output logic  o_rdy,
  // downstream side, towards the arbiter.
  output logic  o_val,
  output logic  o_sop,
  output logic  o_eop,
  output logic  o_err,
  output dat_t  o_dat,
  output mod_t  o_mod,
  output ctl_u  o_ctl,
  input  logic  i_rdy
);

  ctl_u stamp; // incoming control word with the channel id written in.

  // ready while the slot is empty or its beat leaves this cycle.
  assign o_rdy = !o_val || i_rdy;

  always_comb begin
    stamp           = i_ctl;
    stamp.tagd.chan = i_chan; // tag bits below are left as sent.
  end

  // --------------------
  // one-beat register.
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val; // goes low again once drained with nothing new behind it.
    end
  end

  // payload only loads when a beat is really accepted.
  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      o_sop <= i_sop;
      o_eop <= i_eop;
      o_err <= i_err;
      o_dat <= i_dat;
      o_mod <= i_mod;
      o_ctl <= stamp;
    end
  end

  // a stalled beat stays presented and unchanged until the arbiter takes it.
  a_hold_stable : assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && !i_rdy |=> o_val && $stable(o_dat) && $stable(o_ctl) && $stable(o_mod)
      && $stable(o_sop) && $stable(o_eop) && $stable(o_err))
    else $error("input stage changed a stalled beat.");

endmodule

// File: hdl/pkt_mux_top.sv
// Top level of the four-channel packet stream multiplexer.
// Input slices per channel, a packet-locked arbiter, and an output
// slice with per-channel delivered-packet counters.

`include "pkt_mux_defs.svh"

module pkt_mux_top import pkt_stream_pkg::*, pkt_arb_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  arb_mode_e              i_mode,
  // input streams, one lane per channel.
  input  req_t                   i_val,
  input  req_t                   i_sop,
  input  req_t                   i_eop,
  input  req_t                   i_err,
  input  dat_t [`PKT_NUM_IN-1:0] i_dat,
  input  mod_t [`PKT_NUM_IN-1:0] i_mod,
  input  ctl_u [`PKT_NUM_IN-1:0] i_ctl,
  output req_t                   o_rdy,
  // merged output stream.
  output logic                   o_val,
  output logic                   o_sop,
  output logic                   o_eop,
  output logic                   o_err,
  output dat_t                   o_dat,
  output mod_t                   o_mod,
  output ctl_u                   o_ctl,
  input  logic                   i_rdy,
  output cnt_t [`PKT_NUM_IN-1:0] o_pkt_cnt
);

  // --------------------
  // stage to arbiter.
  // --------------------
  req_t                   stg_val, stg_sop, stg_eop, stg_err;
  dat_t [`PKT_NUM_IN-1:0] stg_dat;
  mod_t [`PKT_NUM_IN-1:0] stg_mod;
  ctl_u [`PKT_NUM_IN-1:0] stg_ctl;
  req_t                   arb_rdy; // grant back to the stages.

  // arbiter to output stage.
  logic arb_val, arb_sop, arb_eop, arb_err;
  dat_t arb_dat;
  mod_t arb_mod;
  ctl_u arb_ctl;
  logic out_rdy;

  for (genvar g = 0; g < `PKT_NUM_IN; g++) begin : g_in
    pkt_in_stage pkt_in_stage_inst (
      .i_clk (i_clk),      .i_rst (i_rst),      .i_chan(chan_t'(g)),
      .i_val (i_val[g]),   .i_sop (i_sop[g]),   .i_eop (i_eop[g]),
      .i_err (i_err[g]),   .i_dat (i_dat[g]),   .i_mod (i_mod[g]),
      .i_ctl (i_ctl[g]),   .o_rdy (o_rdy[g]),
      .o_val (stg_val[g]), .o_sop (stg_sop[g]), .o_eop (stg_eop[g]),
      .o_err (stg_err[g]), .o_dat (stg_dat[g]), .o_mod (stg_mod[g]),
      .o_ctl (stg_ctl[g]), .i_rdy (arb_rdy[g])
    );
  end

  pkt_arb pkt_arb_inst (
    .i_clk(i_clk),   .i_rst(i_rst),   .i_mode(i_mode),
    .i_val(stg_val), .i_sop(stg_sop), .i_eop(stg_eop), .i_err(stg_err),
    .i_dat(stg_dat), .i_mod(stg_mod), .i_ctl(stg_ctl), .o_rdy(arb_rdy),
    .o_val(arb_val), .o_sop(arb_sop), .o_eop(arb_eop), .o_err(arb_err),
    .o_dat(arb_dat), .o_mod(arb_mod), .o_ctl(arb_ctl), .i_rdy(out_rdy)
  );

  pkt_out_stage pkt_out_stage_inst (
    .i_clk(i_clk),   .i_rst(i_rst),
    .i_val(arb_val), .i_sop(arb_sop), .i_eop(arb_eop), .i_err(arb_err),
    .i_dat(arb_dat), .i_mod(arb_mod), .i_ctl(arb_ctl), .o_rdy(out_rdy),
    .o_val(o_val),   .o_sop(o_sop),   .o_eop(o_eop),   .o_err(o_err),
    .o_dat(o_dat),   .o_mod(o_mod),   .o_ctl(o_ctl),   .i_rdy(i_rdy),
    .o_pkt_cnt(o_pkt_cnt)
  );

endmodule

// File: hdl/pkt_out_stage.sv
// Output register slice of the packet multiplexer.
// Holds one beat for the downstream sink and counts delivered packets
// per channel, using the channel id carried in the control word.

`include "pkt_mux_defs.svh"

module pkt_out_stage import pkt_stream_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rst,
  // selected beat from the arbiter.
  input  logic                   i_val,
  input  logic                   i_sop,
  input  logic                   i_eop,
  input  logic                   i_err,
  input  dat_t                   i_dat,
  input  mod_t                   i_mod,
  input  ctl_u                   i_ctl,
  output logic                   o_rdy,
  // output stream.
  output logic                   o_val,
  output logic                   o_sop,
  output logic                   o_eop,
  output logic                   o_err,
  output dat_t                   o_dat,
  output mod_t                   o_mod,
  output ctl_u                   o_ctl,
  input  logic                   i_rdy,
  // delivered packets, one counter per channel.
  output cnt_t [`PKT_NUM_IN-1:0] o_pkt_cnt
);

  logic pkt_open; // a sop has been accepted and its eop has not yet.
  logic acc;      // a beat is accepted into the register this cycle.

  assign o_rdy = !o_val || i_rdy; // same rule as the input stages.
  assign acc   = i_val && o_rdy;

  // --------------------
  // one-beat register.
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (acc) begin
      o_sop <= i_sop;
      o_eop <= i_eop;
      o_err <= i_err;
      o_dat <= i_dat;
      o_mod <= i_mod;
      o_ctl <= i_ctl;
    end
  end

  // tracks packet framing on the accepting side of the register.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pkt_open <= 1'b0;
    end else if (acc) begin
      pkt_open <= !i_eop; // a single-beat packet never opens.
    end
  end

  // --------------------
  // delivered-packet counters.
  // --------------------
  // the channel id is read back from the top bits of the leaving ctl word.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pkt_cnt <= '0;
    end else if (o_val && i_rdy && o_eop) begin
      o_pkt_cnt[o_ctl.tagd.chan] <= o_pkt_cnt[o_ctl.tagd.chan] + 1'b1; // wraps.
    end
  end

  // a new packet may only start once the previous one has closed.
  a_no_nested_sop : assert property (@(posedge i_clk) disable iff (i_rst)
    acc && i_sop |-> !pkt_open)
    else $error("sop accepted while a packet was still open.");

endmodule

// File: hdl/pkt_stream_pkg.sv
// Stream word types shared by every stage of the packet multiplexer.
// The control word is a union so the channel id can be read or
// written as a field while the source still sees one flat word.

`include "pkt_mux_defs.svh"

package pkt_stream_pkg;

  // one data beat.
  typedef logic [`PKT_DAT_BITS-1:0] dat_t;

  // valid byte count of an end-of-packet beat, 0 means a full beat.
  typedef logic [`PKT_MOD_BITS-1:0] mod_t;

  // --------------------
  // control word views.
  // --------------------
  typedef struct packed {
    logic [`PKT_CHAN_BITS-1:0]               chan; // channel the beat came in on.
    logic [`PKT_CTL_BITS-`PKT_CHAN_BITS-1:0] tag;  // source tag, passed through.
  } ctl_tag_t;

  // raw is the word as sent, tagd splits it into chan and tag.
  typedef union packed {
    logic [`PKT_CTL_BITS-1:0] raw;
    ctl_tag_t                 tagd;
  } ctl_u;

  // delivered packet count. It wraps at the top.
  typedef logic [15:0] cnt_t;

endpackage

// File: include/pkt_mux_defs.svh
// Sizing macros for the four-channel packet stream multiplexer.
// The packages and the RTL derive every width from these values.

`ifndef PKT_MUX_DEFS_SVH
`define PKT_MUX_DEFS_SVH

// number of input channels feeding the arbiter.
`define PKT_NUM_IN 4

// data beat width in bytes, and the same in bits.
`define PKT_DAT_BYTS 8
`define PKT_DAT_BITS (`PKT_DAT_BYTS * 8)

// width of the sideband control word carried with each beat.
`define PKT_CTL_BITS 8

// bits needed to name one channel. The top bits of ctl hold it.
`define PKT_CHAN_BITS $clog2(`PKT_NUM_IN)

// the mod field counts valid bytes in the last beat, where 0 means all of them.
`define PKT_MOD_BITS $clog2(`PKT_DAT_BYTS)

`endif

// File: pkt_mux.f
+incdir+include
hdl/pkt_stream_pkg.sv
hdl/pkt_arb_pkg.sv
hdl/pkt_in_stage.sv
hdl/pkt_arb.sv
hdl/pkt_out_stage.sv
hdl/pkt_mux_top.sv
dv/pkt_mux_tb.sv
